// File: ibuf_pkg.sv
package ibuf_pkg;

    ////////////////////////////////////////////////////////////
    // ring geometry
    ////////////////////////////////////////////////////////////
    localparam int line_bytes = 16;
    localparam int num_lines  = 4;
    localparam int ring_bytes = line_bytes * num_lines;
    localparam int bip_width  = $clog2(ring_bytes);
    localparam int idx_width  = $clog2(num_lines);

    typedef logic [line_bytes*8-1:0] line_t;
    typedef logic [line_bytes*8-1:0] packet_t;
    typedef logic [bip_width-1:0]    bip_t;
    typedef logic [idx_width-1:0]    line_idx_t;

    // decode length, 1 to 16 when legal
    typedef logic [7:0] ilen_t;

    // upper pointer bits select the line
    function automatic line_idx_t line_of(input bip_t p);
        return line_idx_t'(p >> $clog2(line_bytes));
    endfunction

endpackage

// File: redirect_pkg.sv
package redirect_pkg;

    // declared lowest to highest priority
    typedef enum logic [1:0] {
        src_none    = 2'd0,
        src_branch  = 2'd1,
        src_resteer = 2'd2,
        src_init    = 2'd3
    } redirect_src_t;

    function automatic redirect_src_t pick_src(
        input logic init_v,
        input logic resteer_v,
        input logic branch_v
    );
        redirect_src_t src;
        src = src_none;
        if (branch_v) begin
            src = src_branch;
        end
        if (resteer_v) begin
            src = src_resteer;
        end
        if (init_v) begin
            src = src_init;
        end
        return src;
    endfunction

endpackage

// File: lane_rotator.sv
module lane_rotator import ibuf_pkg::*; (
    input  logic [ring_bytes-1:0] lane_in,
    input  bip_t                  amount,
    output logic [ring_bytes-1:0] lane_out
);

    // stage k rotates by 2**k when amount[k] is set
    always_comb begin
        lane_out = lane_in;
        for (int k = 0; k < bip_width; k++) begin
            if (amount[k]) begin
                // out bit i takes in bit (i + 2**k) mod ring_bytes
                lane_out = (lane_out >> (1 << k)) | (lane_out << (ring_bytes - (1 << k)));
            end
        end
    end

endmodule

// File: byte_rotator.sv
module byte_rotator import ibuf_pkg::*; (
    input  line_t   line_0,
    input  line_t   line_1,
    input  line_t   line_2,
    input  line_t   line_3,
    input  bip_t    amount,
    output packet_t packet
);

    ////////////////////////////////////////////////////////////
    // ring in byte order, line 0 at the bottom
    ////////////////////////////////////////////////////////////
    logic [ring_bytes*8-1:0] ring;
    logic [ring_bytes*8-1:0] ring_rot;

    assign ring = {line_3, line_2, line_1, line_0};

    ////////////////////////////////////////////////////////////
    // one lane per bit position of a byte
    ////////////////////////////////////////////////////////////
    for (genvar n = 0; n < 8; n++) begin : g_lane
        logic [ring_bytes-1:0] lane_in;
        logic [ring_bytes-1:0] lane_out;

        for (genvar j = 0; j < ring_bytes; j++) begin : g_gather
            assign lane_in[j] = ring[j*8 + n];
        end

        lane_rotator lane_rotator_i (
            .lane_in  (lane_in),
            .amount   (amount),
            .lane_out (lane_out)
        );

        // put the rotated bit back into its byte
        for (genvar j = 0; j < ring_bytes; j++) begin : g_scatter
            assign ring_rot[j*8 + n] = lane_out[j];
        end
    end

    // byte 0 of the window is the byte at the pointer
    assign packet = ring_rot[line_bytes*8-1:0];

endmodule

// File: ibuf_ring.sv
module ibuf_ring import ibuf_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,

    ////////////////////////////////////////////////////////////
    // fill from memory
    ////////////////////////////////////////////////////////////
    input  line_t                fill_line,
    input  logic                 fill_valid,
    output logic                 fill_ready,

    ////////////////////////////////////////////////////////////
    // release and flush from the aligner
    ////////////////////////////////////////////////////////////
    input  logic                 release_valid,
    input  line_idx_t            release_line,
    input  logic                 flush,
    input  line_idx_t            flush_line,

    output line_t                line_0,
    output line_t                line_1,
    output line_t                line_2,
    output line_t                line_3,
    output logic [num_lines-1:0] line_valid
);

    line_t                lines [num_lines];
    logic [num_lines-1:0] valid_q;
    line_idx_t            fill_ptr;
    logic                 fill_fire;

    // slot must be free, nothing accepted while flushing
    assign fill_ready = !valid_q[fill_ptr] && !flush;
    assign fill_fire  = fill_valid && fill_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q  <= '0;
            fill_ptr <= '0;
        end else if (flush) begin
            valid_q  <= '0;
            fill_ptr <= flush_line;
        end else begin
            if (release_valid) begin
                valid_q[release_line] <= 1'b0;
            end
            // released slot is never the empty fill slot
            if (fill_fire) begin
                valid_q[fill_ptr] <= 1'b1;
                fill_ptr          <= fill_ptr + line_idx_t'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_fire) begin
            lines[fill_ptr] <= fill_line;
        end
    end

    assign line_0     = lines[0];
    assign line_1     = lines[1];
    assign line_2     = lines[2];
    assign line_3     = lines[3];
    assign line_valid = valid_q;

endmodule

// File: fetch_align.sv
module fetch_align import ibuf_pkg::*, redirect_pkg::*; (
    input  logic                 clk,
    input  logic                 arst_n,

    input  logic [num_lines-1:0] line_valid,

    ////////////////////////////////////////////////////////////
    // decode side
    ////////////////////////////////////////////////////////////
    output logic                 packet_valid,
    input  logic                 packet_ready,
    input  ilen_t                packet_len,

    ////////////////////////////////////////////////////////////
    // control flow redirects
    ////////////////////////////////////////////////////////////
    input  logic                 init_valid,
    input  logic                 resteer_valid,
    input  logic                 branch_taken,
    input  bip_t                 init_bip,
    input  bip_t                 resteer_bip,
    input  bip_t                 branch_bip,

    output bip_t                 bip,
    output logic                 release_valid,
    output line_idx_t            release_line,
    output logic                 flush,
    output line_idx_t            flush_line
);

    bip_t          bip_q;
    bip_t          bip_adv;
    bip_t          target;
    logic [7:0]    bip_sum;
    line_idx_t     cur_line;
    line_idx_t     next_line;
    redirect_src_t src;
    logic          redirect;
    logic          accept;

    // window spans the line at bip and the one after it
    assign cur_line     = line_of(bip_q);
    assign next_line    = cur_line + line_idx_t'(1);
    assign packet_valid = line_valid[cur_line] && line_valid[next_line];
    assign accept       = packet_valid && packet_ready;

    // eight-bit advance, wraps mod 64 on the low bits
    assign bip_sum = {2'b00, bip_q} + packet_len;
    assign bip_adv = bip_sum[bip_width-1:0];

    assign src      = pick_src(init_valid, resteer_valid, branch_taken);
    assign redirect = (src != src_none);

    always_comb begin
        case (src)
            src_init:    target = init_bip;
            src_resteer: target = resteer_bip;
            src_branch:  target = branch_bip;
            default:     target = bip_q;
        endcase
    end

    // redirect beats a same-cycle accept
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bip_q <= '0;
        end else if (redirect) begin
            bip_q <= target;
        end else if (accept) begin
            bip_q <= bip_adv;
        end
    end

    assign flush      = redirect;
    assign flush_line = line_of(target);

    // old line is done once the pointer leaves it
    assign release_valid = accept && !redirect && (line_of(bip_adv) != cur_line);
    assign release_line  = cur_line;

    assign bip = bip_q;

endmodule

// File: fetch_unit.sv
module fetch_unit import ibuf_pkg::*; (
    input  logic    clk,
    input  logic    arst_n,

    ////////////////////////////////////////////////////////////
    // line fill
    ////////////////////////////////////////////////////////////
    input  line_t   fill_line,
    input  logic    fill_valid,
    output logic    fill_ready,

    ////////////////////////////////////////////////////////////
    // packet to decode
    ////////////////////////////////////////////////////////////
    output packet_t packet,
    output logic    packet_valid,
    input  logic    packet_ready,
    input  ilen_t   packet_len,

    ////////////////////////////////////////////////////////////
    // redirects
    ////////////////////////////////////////////////////////////
    input  logic    init_valid,
    input  bip_t    init_bip,
    input  logic    resteer_valid,
    input  bip_t    resteer_bip,
    input  logic    branch_taken,
    input  bip_t    branch_bip,

    output bip_t    bip
);

    line_t                line_0;
    line_t                line_1;
    line_t                line_2;
    line_t                line_3;
    logic [num_lines-1:0] line_valid;
    logic                 release_valid;
    line_idx_t            release_line;
    logic                 flush;
    line_idx_t            flush_line;

    ibuf_ring ibuf_ring_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fill_line     (fill_line),
        .fill_valid    (fill_valid),
        .fill_ready    (fill_ready),
        .release_valid (release_valid),
        .release_line  (release_line),
        .flush         (flush),
        .flush_line    (flush_line),
        .line_0        (line_0),
        .line_1        (line_1),
        .line_2        (line_2),
        .line_3        (line_3),
        .line_valid    (line_valid)
    );

    fetch_align fetch_align_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .line_valid    (line_valid),
        .packet_valid  (packet_valid),
        .packet_ready  (packet_ready),
        .packet_len    (packet_len),
        .init_valid    (init_valid),
        .resteer_valid (resteer_valid),
        .branch_taken  (branch_taken),
        .init_bip      (init_bip),
        .resteer_bip   (resteer_bip),
        .branch_bip    (branch_bip),
        .bip           (bip),
        .release_valid (release_valid),
        .release_line  (release_line),
        .flush         (flush),
        .flush_line    (flush_line)
    );

    // window rotates on the current pointer
    byte_rotator byte_rotator_i (
        .line_0 (line_0),
        .line_1 (line_1),
        .line_2 (line_2),
        .line_3 (line_3),
        .amount (bip),
        .packet (packet)
    );

endmodule

// File: fetch_unit_tb.sv
module fetch_unit_tb import ibuf_pkg::*, redirect_pkg::*;;

    localparam int wait_limit = 50;

    logic    clk;
    logic    arst_n;
    line_t   fill_line;
    logic    fill_valid;
    logic    fill_ready;
    packet_t packet;
    logic    packet_valid;
    logic    packet_ready;
    ilen_t   packet_len;
    logic    init_valid;
    bip_t    init_bip;
    logic    resteer_valid;
    bip_t    resteer_bip;
    logic    branch_taken;
    bip_t    branch_bip;
    bip_t    bip;

    // byte-level ring model
    logic [7:0]           ring_model [ring_bytes];
    logic [num_lines-1:0] model_valid;
    line_idx_t            model_fill_ptr;
    bip_t                 model_bip;
    integer               seed;
    int                   errors;
    int                   timeouts;

    fetch_unit fetch_unit_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .fill_line     (fill_line),
        .fill_valid    (fill_valid),
        .fill_ready    (fill_ready),
        .packet        (packet),
        .packet_valid  (packet_valid),
        .packet_ready  (packet_ready),
        .packet_len    (packet_len),
        .init_valid    (init_valid),
        .init_bip      (init_bip),
        .resteer_valid (resteer_valid),
        .resteer_bip   (resteer_bip),
        .branch_taken  (branch_taken),
        .branch_bip    (branch_bip),
        .bip           (bip)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////
    task automatic check_packet(input string name, input packet_t exp, input packet_t got);
        if (exp !== got) begin
            $display("error %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_bip(input string name, input bip_t exp, input bip_t got);
        if (exp !== got) begin
            $display("error %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (exp !== got) begin
            $display("error %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    // window of 16 bytes starting at the model pointer
    function automatic packet_t expect_packet();
        packet_t pkt;
        pkt = '0;
        for (int k = line_bytes - 1; k >= 0; k--) begin
            pkt = {pkt[line_bytes*8-9:0], ring_model[model_bip + bip_t'(k)]};
        end
        return pkt;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus tasks, each starts and ends 2 units after a rising edge
    ////////////////////////////////////////////////////////////
    task automatic fill_line_task();
        line_t data;
        int    cnt;
        data       = {$random(seed), $random(seed), $random(seed), $random(seed)};
        fill_line  = data;
        fill_valid = 1'b1;
        cnt        = 0;
        @(negedge clk);
        while (!fill_ready && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!fill_ready) begin
            $display("timeout while waiting for the buffer to take a line");
            timeouts++;
        end else begin
            for (int b = 0; b < line_bytes; b++) begin
                ring_model[{model_fill_ptr, 4'(b)}] = data[7:0];
                data = data >> 8;
            end
            model_valid[model_fill_ptr] = 1'b1;
            model_fill_ptr = model_fill_ptr + line_idx_t'(1);
        end
        @(posedge clk);
        #2;
        fill_valid = 1'b0;
    endtask

    task automatic consume_task(input ilen_t len);
        int   cnt;
        bip_t next_bip;
        packet_ready = 1'b1;
        packet_len   = len;
        cnt          = 0;
        @(negedge clk);
        while (!packet_valid && cnt < wait_limit) begin
            @(negedge clk);
            cnt++;
        end
        if (!packet_valid) begin
            $display("timeout while waiting for a valid packet");
            timeouts++;
            packet_ready = 1'b0;
        end else begin
            check_bip("bip", model_bip, bip);
            check_packet("packet", expect_packet(), packet);
            next_bip = model_bip + bip_t'(len);
            // leaving a line frees it
            if (next_bip[5:4] != model_bip[5:4]) begin
                model_valid[model_bip[5:4]] = 1'b0;
            end
            model_bip = next_bip;
        end
        @(posedge clk);
        #2;
        packet_ready = 1'b0;
    endtask

    task automatic refill_freed_slot();
        if (!model_valid[model_fill_ptr]) begin
            @(negedge clk);
            check_flag("fill_ready", 1'b1, fill_ready);
            @(posedge clk);
            #2;
            fill_line_task();
        end
    endtask

    task automatic redirect_task(input logic iv, input logic rv, input logic bv,
                                 input bip_t ib, input bip_t rb, input bip_t bb,
                                 input logic with_accept);
        redirect_src_t src;
        bip_t          tgt;
        init_valid    = iv;
        resteer_valid = rv;
        branch_taken  = bv;
        init_bip      = ib;
        resteer_bip   = rb;
        branch_bip    = bb;
        packet_ready  = with_accept;
        packet_len    = 8'd4;
        if (iv) begin
            src = src_init;
        end else if (rv) begin
            src = src_resteer;
        end else if (bv) begin
            src = src_branch;
        end else begin
            src = src_none;
        end
        case (src)
            src_init:    tgt = ib;
            src_resteer: tgt = rb;
            src_branch:  tgt = bb;
            default:     tgt = model_bip;
        endcase
        @(posedge clk);
        #2;
        init_valid    = 1'b0;
        resteer_valid = 1'b0;
        branch_taken  = 1'b0;
        packet_ready  = 1'b0;
        model_bip      = tgt;
        model_valid    = '0;
        model_fill_ptr = tgt[5:4];
        @(negedge clk);
        check_bip("bip", tgt, bip);
        check_flag("packet_valid", 1'b0, packet_valid);
        check_flag("fill_ready", 1'b1, fill_ready);
        @(posedge clk);
        #2;
    endtask

    // len changes must not move anything while not ready
    task automatic hold_and_compare(input int cycles);
        packet_t held;
        packet_ready = 1'b0;
        held = expect_packet();
        for (int i = 0; i < cycles; i++) begin
            packet_len = ilen_t'($random(seed));
            @(negedge clk);
            check_flag("packet_valid", 1'b1, packet_valid);
            check_bip("bip", model_bip, bip);
            check_packet("packet", held, packet);
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        seed          = 32'he18a_19b2;
        errors        = 0;
        timeouts      = 0;
        clk           = 1'b0;
        arst_n        = 1'b0;
        fill_line     = '0;
        fill_valid    = 1'b0;
        packet_ready  = 1'b0;
        packet_len    = 8'd1;
        init_valid    = 1'b0;
        init_bip      = '0;
        resteer_valid = 1'b0;
        resteer_bip   = '0;
        branch_taken  = 1'b0;
        branch_bip    = '0;
        model_valid    = '0;
        model_fill_ptr = '0;
        model_bip      = '0;
        repeat (2) @(posedge clk);
        #2;
        arst_n = 1'b1;

        @(negedge clk);
        check_bip("bip", 6'd0, bip);
        check_flag("packet_valid", 1'b0, packet_valid);
        check_flag("fill_ready", 1'b1, fill_ready);
        @(posedge clk);
        #2;

        // one line is not a full window
        fill_line_task();
        @(negedge clk);
        check_flag("packet_valid", 1'b0, packet_valid);
        @(posedge clk);
        #2;
        fill_line_task();
        @(negedge clk);
        check_flag("packet_valid", 1'b1, packet_valid);
        check_packet("packet", expect_packet(), packet);
        @(posedge clk);
        #2;

        // full ring, then walk it with every length
        fill_line_task();
        fill_line_task();
        @(negedge clk);
        check_flag("fill_ready", 1'b0, fill_ready);
        @(posedge clk);
        #2;
        for (int len = 1; len <= 16; len++) begin
            consume_task(ilen_t'(len));
            refill_freed_slot();
        end

        hold_and_compare(4);
        redirect_task(1'b0, 1'b0, 1'b1, 6'h00, 6'h00, 6'h12, 1'b1);
        fill_line_task();
        fill_line_task();
        consume_task(8'd2);

        redirect_task(1'b1, 1'b1, 1'b1, 6'h25, 6'h0b, 6'h3c, 1'b0);
        fill_line_task();
        fill_line_task();
        consume_task(8'd3);
        redirect_task(1'b0, 1'b1, 1'b1, 6'h25, 6'h0b, 6'h3c, 1'b0);
        fill_line_task();
        fill_line_task();
        consume_task(8'd5);
        // window crosses from line 3 into line 0
        redirect_task(1'b0, 1'b0, 1'b1, 6'h25, 6'h0b, 6'h3c, 1'b0);
        fill_line_task();
        fill_line_task();
        consume_task(8'd7);

        $display("errors %0d timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// File: list.f
ibuf_pkg.sv
redirect_pkg.sv
lane_rotator.sv
byte_rotator.sv
ibuf_ring.sv
fetch_align.sv
fetch_unit.sv
fetch_unit_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f list.f --top-module fetch_unit_tb -o fetch_unit_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/fetch_unit_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
    exit 0
fi
exit 1
